/* include/tiny16_macros.svh */
`ifndef TINY16_MACROS_SVH
`define TINY16_MACROS_SVH

`define TINY16_WORD_W    16
`define TINY16_REG_N     16
`define TINY16_SP        15
`define TINY16_MEM_DEPTH 256

`define TINY16_OP_NOP  4'h0
`define TINY16_OP_LDI  4'h1
`define TINY16_OP_ALU  4'h2
`define TINY16_OP_LD   4'h3
`define TINY16_OP_ST   4'h4
`define TINY16_OP_BR   4'h5
`define TINY16_OP_LDW  4'h6
`define TINY16_OP_PUSH 4'h7
`define TINY16_OP_HLT  4'h8

`define TINY16_ALU_ADD 4'h0
`define TINY16_ALU_SUB 4'h1
`define TINY16_ALU_AND 4'h2
`define TINY16_ALU_OR  4'h3
`define TINY16_ALU_XOR 4'h4
`define TINY16_ALU_SHL 4'h5
`define TINY16_ALU_SHR 4'h6
`define TINY16_ALU_MUL 4'h7

// Control word selector encodings.
`define TINY16_WA_DST  2'd0
`define TINY16_WA_DST1 2'd1
`define TINY16_WA_SP   2'd2

`define TINY16_WD_IMM     3'd0
`define TINY16_WD_ALU_LO  3'd1
`define TINY16_WD_ALU_HI  3'd2
`define TINY16_WD_DATA_IN 3'd3
`define TINY16_WD_SP_DEC  3'd4

`define TINY16_AD_PC     2'd0
`define TINY16_AD_SRC    2'd1
`define TINY16_AD_SP_DEC 2'd2

`define TINY16_PC_HOLD   2'd0
`define TINY16_PC_INC1   2'd1
`define TINY16_PC_INC2   2'd2
`define TINY16_PC_BRANCH 2'd3

`endif

/* logic/tiny16_pkg.sv */
`include "tiny16_macros.svh"

package tiny16_pkg;

    typedef logic [`TINY16_WORD_W-1:0] word_t;
    typedef logic [$clog2(`TINY16_REG_N)-1:0] reg_addr_t;
    typedef logic [3:0] opcode_t;
    typedef logic [3:0] alu_op_t;

    // Microcode stage, S0 is always the instruction fetch.
    typedef enum logic [1:0] {
        S0,
        S1,
        S2,
        S3
    } stage_t;

    typedef struct packed {
        logic c;
        logic z;
        logic n;
    } flags_t;

    typedef struct packed {
        logic       reg_we;
        logic [1:0] reg_waddr_sel;
        logic [2:0] reg_wdata_sel;
        logic       mem_rd;
        logic       mem_wr;
        logic [1:0] addr_sel;
        logic       fetch2;    // Access targets the word after the instruction.
        logic [1:0] pc_sel;
        logic       alu_en;
        logic       last;
        logic       halt;
        logic       err;
    } micro_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } host_req_t;

endpackage

/* logic/tiny16_alu.sv */
`timescale 1ns/1ps
`include "tiny16_macros.svh"

module tiny16_alu import tiny16_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    en,
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output word_t   result_hi,
    output flags_t  flags
);
    logic [`TINY16_WORD_W:0]     sum;
    logic [2*`TINY16_WORD_W-1:0] product;
    logic                        carry;

    assign product   = a * b;
    assign result_hi = product[2*`TINY16_WORD_W-1:`TINY16_WORD_W];

    always_comb begin
        sum    = '0;
        carry  = 1'b0;
        result = '0;
        case (op)
            `TINY16_ALU_ADD: begin
                sum    = {1'b0, a} + {1'b0, b};
                result = sum[`TINY16_WORD_W-1:0];
                carry  = sum[`TINY16_WORD_W];
            end
            `TINY16_ALU_SUB: begin
                sum    = {1'b0, a} - {1'b0, b};
                result = sum[`TINY16_WORD_W-1:0];
                carry  = sum[`TINY16_WORD_W]; // Borrow.
            end
            `TINY16_ALU_AND: result = a & b;
            `TINY16_ALU_OR:  result = a | b;
            `TINY16_ALU_XOR: result = a ^ b;
            `TINY16_ALU_SHL: begin
                result = {a[`TINY16_WORD_W-2:0], 1'b0};
                carry  = a[`TINY16_WORD_W-1];
            end
            `TINY16_ALU_SHR: begin
                result = {1'b0, a[`TINY16_WORD_W-1:1]};
                carry  = a[0];
            end
            `TINY16_ALU_MUL: result = product[`TINY16_WORD_W-1:0];
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            flags <= '0;
        end else if (en) begin
            flags.c <= carry;
            flags.z <= (result == '0);
            flags.n <= result[`TINY16_WORD_W-1];
        end
    end

endmodule

/* logic/tiny16_regfile.sv */
`timescale 1ns/1ps
`include "tiny16_macros.svh"

module tiny16_regfile import tiny16_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t src_addr,
    input  reg_addr_t dst_addr,
    output word_t     src_data,
    output word_t     dst_data,
    output word_t     sp_data
);
    word_t regs [`TINY16_REG_N];

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `TINY16_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign src_data = regs[src_addr];
    assign dst_data = regs[dst_addr];
    assign sp_data  = regs[`TINY16_SP]; // Stack pointer is always visible.

endmodule

/* logic/tiny16_microcode.sv */
`timescale 1ns/1ps
`include "tiny16_macros.svh"

module tiny16_microcode import tiny16_pkg::*; (
    input  opcode_t opcode,
    input  logic    cond_pass,
    input  stage_t  stage,
    output micro_t  micro
);

    always_comb begin
        micro = '0;
        case (stage)
            S0: begin
                // Fetch is the same for every instruction, pc moves later.
                micro.mem_rd   = 1'b1;
                micro.addr_sel = `TINY16_AD_PC;
                micro.pc_sel   = `TINY16_PC_HOLD;
            end
            S1: begin
                micro.last = 1'b1;
                case (opcode)
                    `TINY16_OP_NOP: micro.pc_sel = `TINY16_PC_INC1;
                    `TINY16_OP_LDI: begin
                        micro.reg_we        = 1'b1;
                        micro.reg_waddr_sel = `TINY16_WA_DST;
                        micro.reg_wdata_sel = `TINY16_WD_IMM;
                        micro.pc_sel        = `TINY16_PC_INC1;
                    end
                    `TINY16_OP_ALU: begin
                        micro.alu_en        = 1'b1;
                        micro.reg_we        = 1'b1;
                        micro.reg_waddr_sel = `TINY16_WA_DST;
                        micro.reg_wdata_sel = `TINY16_WD_ALU_LO;
                        micro.pc_sel        = `TINY16_PC_INC1;
                    end
                    `TINY16_OP_LD: begin
                        micro.mem_rd        = 1'b1;
                        micro.addr_sel      = `TINY16_AD_SRC;
                        micro.reg_we        = 1'b1;
                        micro.reg_waddr_sel = `TINY16_WA_DST;
                        micro.reg_wdata_sel = `TINY16_WD_DATA_IN;
                        micro.pc_sel        = `TINY16_PC_INC1;
                    end
                    `TINY16_OP_ST: begin
                        micro.mem_wr   = 1'b1;
                        micro.addr_sel = `TINY16_AD_SRC;
                        micro.pc_sel   = `TINY16_PC_INC1;
                    end
                    `TINY16_OP_BR: begin
                        micro.pc_sel = cond_pass ? `TINY16_PC_BRANCH : `TINY16_PC_INC1;
                    end
                    `TINY16_OP_LDW: begin
                        micro.mem_rd   = 1'b1;
                        micro.addr_sel = `TINY16_AD_PC;
                        micro.fetch2   = 1'b1;
                        micro.last     = 1'b0;
                    end
                    `TINY16_OP_PUSH: begin
                        // Store at sp-1 and write sp-1 back on the same edge.
                        micro.mem_wr        = 1'b1;
                        micro.addr_sel      = `TINY16_AD_SP_DEC;
                        micro.reg_we        = 1'b1;
                        micro.reg_waddr_sel = `TINY16_WA_SP;
                        micro.reg_wdata_sel = `TINY16_WD_SP_DEC;
                        micro.pc_sel        = `TINY16_PC_INC1;
                    end
                    `TINY16_OP_HLT: micro.halt = 1'b1;
                    default: begin
                        micro.halt = 1'b1;
                        micro.err  = 1'b1;
                    end
                endcase
            end
            S2: begin
                micro.last = 1'b1;
                case (opcode)
                    `TINY16_OP_ALU: begin // Only reached for multiply.
                        micro.reg_we        = 1'b1;
                        micro.reg_waddr_sel = `TINY16_WA_DST1;
                        micro.reg_wdata_sel = `TINY16_WD_ALU_HI;
                    end
                    `TINY16_OP_LDW: begin
                        micro.reg_we        = 1'b1;
                        micro.reg_waddr_sel = `TINY16_WA_DST;
                        micro.reg_wdata_sel = `TINY16_WD_IMM;
                        micro.pc_sel        = `TINY16_PC_INC2;
                    end
                    default: micro.last = 1'b1;
                endcase
            end
            default: micro.last = 1'b1;
        endcase
    end

endmodule

/* logic/tiny16_core.sv */
`timescale 1ns/1ps
`include "tiny16_macros.svh"

module tiny16_core import tiny16_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   run,
    output word_t  address,
    output word_t  data_out,
    input  word_t  data_in,
    output logic   rd,
    output logic   wr,
    input  logic   ready,
    output logic   hlt,
    output logic   error,
    output stage_t stage
);
    word_t      pc;
    word_t      pc_next;
    word_t      instr;
    word_t      imm;      // Sign-extended imm8, or the second word of LDW.
    word_t      mul_hi;
    micro_t     micro;
    opcode_t    opcode;
    reg_addr_t  src_addr;
    reg_addr_t  dst_addr;
    reg_addr_t  waddr;
    word_t      src_data;
    word_t      dst_data;
    word_t      sp_data;
    word_t      sp_dec;
    word_t      wdata;
    word_t      alu_result;
    word_t      alu_hi;
    flags_t     flags;
    logic [2:0] cond_hits;
    logic       cond_pass;
    logic       go;
    logic       step;
    logic       mul_op;
    logic       last;

    assign opcode   = instr[15:12];
    assign dst_addr = instr[11:8];
    assign src_addr = instr[7:4];
    assign sp_dec   = sp_data - word_t'(1);

    assign cond_hits = instr[10:8] & {flags.c, flags.z, flags.n};
    assign cond_pass = (|cond_hits) ^ instr[11];

    // A new instruction starts only while run is high.
    assign go   = !hlt && (stage != S0 || run);
    assign rd   = go && micro.mem_rd;
    assign wr   = go && micro.mem_wr;
    assign step = go && (!(micro.mem_rd || micro.mem_wr) || ready);

    assign mul_op = (opcode == `TINY16_OP_ALU) && (instr[3:0] == `TINY16_ALU_MUL);
    assign last   = micro.last && !(mul_op && stage == S1); // Multiply adds a stage.

    assign data_out = dst_data;

    tiny16_microcode u_microcode (
        .opcode    (opcode),
        .cond_pass (cond_pass),
        .stage     (stage),
        .micro     (micro)
    );

    tiny16_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .we       (micro.reg_we && step),
        .waddr    (waddr),
        .wdata    (wdata),
        .src_addr (src_addr),
        .dst_addr (dst_addr),
        .src_data (src_data),
        .dst_data (dst_data),
        .sp_data  (sp_data)
    );

    tiny16_alu u_alu (
        .clk       (clk),
        .reset     (reset),
        .en        (micro.alu_en && step),
        .op        (alu_op_t'(instr[3:0])),
        .a         (dst_data),
        .b         (src_data),
        .result    (alu_result),
        .result_hi (alu_hi),
        .flags     (flags)
    );

    always_comb begin
        case (micro.reg_waddr_sel)
            `TINY16_WA_DST1: waddr = dst_addr + reg_addr_t'(1);
            `TINY16_WA_SP:   waddr = reg_addr_t'(`TINY16_SP);
            default:         waddr = dst_addr;
        endcase
        case (micro.reg_wdata_sel)
            `TINY16_WD_ALU_LO:  wdata = alu_result;
            `TINY16_WD_ALU_HI:  wdata = mul_hi;
            `TINY16_WD_DATA_IN: wdata = data_in;
            `TINY16_WD_SP_DEC:  wdata = sp_dec;
            default:            wdata = imm;
        endcase
        case (micro.addr_sel)
            `TINY16_AD_SRC:    address = src_data;
            `TINY16_AD_SP_DEC: address = sp_dec;
            default:           address = micro.fetch2 ? pc + word_t'(1) : pc;
        endcase
        case (micro.pc_sel)
            `TINY16_PC_INC1:   pc_next = pc + word_t'(1);
            `TINY16_PC_INC2:   pc_next = pc + word_t'(2);
            `TINY16_PC_BRANCH: pc_next = pc + word_t'(1) + imm;
            default:           pc_next = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            stage <= S0;
            pc    <= '0;
            hlt   <= 1'b0;
            error <= 1'b0;
        end else if (step) begin
            stage <= last ? S0 : stage_t'(stage + 2'd1);
            pc    <= pc_next;
            if (micro.halt) begin
                hlt <= 1'b1;
            end
            if (micro.err) begin
                error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && stage == S0) begin
            instr <= data_in;
            imm   <= {{8{data_in[7]}}, data_in[7:0]};
        end else if (step && micro.fetch2) begin
            imm <= data_in;
        end
        if (micro.alu_en && step) begin
            mul_hi <= alu_hi; // Kept for the second multiply stage.
        end
    end

endmodule

/* logic/tiny16_memory.sv */
`timescale 1ns/1ps
`include "tiny16_macros.svh"

module tiny16_memory import tiny16_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  word_t     address,
    input  word_t     wdata,
    output word_t     rdata,
    input  logic      rd,
    input  logic      wr,
    output logic      ready,
    input  logic      host_req,
    input  host_req_t host_cmd,
    output logic      host_ack,
    output word_t     host_rdata
);
    localparam int AW = $clog2(`TINY16_MEM_DEPTH);

    typedef enum logic [1:0] {
        H_IDLE,
        H_ACCESS,
        H_ACK
    } host_state_t;

    word_t       ram [`TINY16_MEM_DEPTH];
    logic [1:0]  wait_cnt;
    logic        core_req;
    logic        host_go;
    host_state_t host_state;

    assign core_req = rd || wr;
    assign ready    = core_req && (wait_cnt == address[1:0]); // 1 + address[1:0] cycles.
    assign rdata    = ram[address[AW-1:0]];

    // The host only gets the RAM while the core is quiet.
    assign host_go  = (host_state == H_ACCESS) && !core_req;
    assign host_ack = (host_state == H_ACK);

    always_ff @(posedge clk) begin
        if (!reset || !core_req || ready) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            host_state <= H_IDLE;
        end else begin
            case (host_state)
                H_IDLE:   if (host_req) host_state <= H_ACCESS;
                H_ACCESS: if (host_go) host_state <= H_ACK;
                H_ACK:    if (!host_req) host_state <= H_IDLE;
                default:  host_state <= H_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr && ready) begin
            ram[address[AW-1:0]] <= wdata;
        end else if (host_go && host_cmd.we) begin
            ram[host_cmd.addr[AW-1:0]] <= host_cmd.wdata;
        end
        if (host_go) begin
            host_rdata <= ram[host_cmd.addr[AW-1:0]];
        end
    end

endmodule

/* logic/tiny16_system.sv */
`timescale 1ns/1ps

module tiny16_system import tiny16_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  logic      host_req,
    input  host_req_t host_cmd,
    output logic      host_ack,
    output word_t     host_rdata,
    output logic      hlt,
    output logic      error,
    output stage_t    stage
);
    word_t address;
    word_t data_out;
    word_t data_in;
    logic  rd;
    logic  wr;
    logic  ready;

    tiny16_core u_core (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .address  (address),
        .data_out (data_out),
        .data_in  (data_in),
        .rd       (rd),
        .wr       (wr),
        .ready    (ready),
        .hlt      (hlt),
        .error    (error),
        .stage    (stage)
    );

    tiny16_memory u_mem (
        .clk        (clk),
        .reset      (reset),
        .address    (address),
        .wdata      (data_out),
        .rdata      (data_in),
        .rd         (rd),
        .wr         (wr),
        .ready      (ready),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata)
    );

endmodule

/* tb/tiny16_assert.sv */
`timescale 1ns/1ps

module tiny16_assert import tiny16_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  rd,
    input logic  wr,
    input logic  ready,
    input word_t address,
    input logic  host_req,
    input logic  host_ack,
    input logic  hlt
);
    int unsigned fail_count = 0;

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!reset) !(rd && wr))
        else begin
            fail_count++;
            $error("rd and wr are high in the same cycle");
        end

    // A waiting request keeps its address until ready.
    address_held: assert property (@(posedge clk) disable iff (!reset)
        (rd || wr) && !ready |=> $stable(address))
        else begin
            fail_count++;
            $error("address changed while a bus request waited for ready");
        end

    // The ack is registered, so the request must have been high on the edge that raised it.
    ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
        $rose(host_ack) |-> $past(host_req))
        else begin
            fail_count++;
            $error("host_ack rose while host_req was low");
        end

    quiet_after_halt: assert property (@(posedge clk) disable iff (!reset)
        hlt |-> !rd && !wr)
        else begin
            fail_count++;
            $error("bus request seen after hlt");
        end

endmodule

bind tiny16_system tiny16_assert u_assert (
    .clk      (clk),
    .reset    (reset),
    .rd       (rd),
    .wr       (wr),
    .ready    (ready),
    .address  (address),
    .host_req (host_req),
    .host_ack (host_ack),
    .hlt      (hlt)
);

/* tb/tiny16_tb.sv */
`timescale 1ns/1ps
`include "tiny16_macros.svh"

module tiny16_tb import tiny16_pkg::*; ();

    localparam int    NT          = 20;
    localparam int    PW          = 8;
    localparam int    CYCLE_LIMIT = 400 * NT;
    localparam word_t HALT_WORD   = {`TINY16_OP_HLT, 12'h000};

    logic      clk;
    logic      reset;
    logic      run;
    logic      host_req;
    host_req_t host_cmd;
    logic      host_ack;
    word_t     host_rdata;
    logic      hlt;
    logic      error;
    stage_t    stage;

    string      t_name  [NT];
    word_t      t_prog  [NT][PW];
    word_t      t_addr  [NT];
    word_t      t_exp   [NT];
    logic       t_err   [NT];
    logic [2:0] t_flags [NT]; // {c, z, n}
    logic       t_chkf  [NT];
    string      alu_names [8] = '{"add", "sub", "and", "or", "xor", "shl", "shr", "mul"};

    word_t       code [$];
    int          n_entries;
    int          errors;
    int          checks;
    int          cycles;
    int unsigned assert_fails;

    tiny16_system u_dut (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .hlt        (hlt),
        .error      (error),
        .stage      (stage)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t enc(input logic [3:0] op, input logic [3:0] d,
                                  input logic [3:0] s, input logic [3:0] lo);
        return {op, d, s, lo};
    endfunction

    function automatic word_t enc_imm(input logic [3:0] op, input logic [3:0] d,
                                      input logic [7:0] imm);
        return {op, d, imm};
    endfunction

    function automatic word_t sext8(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    // Marker left in memory ahead of each run, so a missing store is visible.
    function automatic word_t sentinel(input int k);
        return 16'h5a00 | word_t'(k);
    endfunction

    function automatic logic branch_taken(input logic [3:0] cond, input logic [2:0] czn);
        return ((cond[2:0] & czn) != 3'b000) ^ cond[3];
    endfunction

    // Returns {c, z, n, high word, low word}.
    function automatic logic [34:0] alu_model(input logic [3:0] op, input word_t a,
                                              input word_t b);
        logic [31:0] prod;
        word_t       lo;
        word_t       hi;
        logic        c;
        prod = {16'h0000, a} * {16'h0000, b};
        hi   = prod[31:16];
        c    = 1'b0;
        case (op)
            `TINY16_ALU_ADD: begin
                lo = a + b;
                c  = (lo < a); // Wrapped around, so there was a carry.
            end
            `TINY16_ALU_SUB: begin
                lo = a - b;
                c  = (a < b);
            end
            `TINY16_ALU_AND: lo = a & b;
            `TINY16_ALU_OR:  lo = a | b;
            `TINY16_ALU_XOR: lo = a ^ b;
            `TINY16_ALU_SHL: begin
                lo = a << 1;
                c  = a[15];
            end
            `TINY16_ALU_SHR: begin
                lo = a >> 1;
                c  = a[0];
            end
            default: lo = prod[15:0];
        endcase
        return {c, lo == 16'h0000, lo[15], hi, lo};
    endfunction

    task automatic add_entry(input string name, input word_t addr, input word_t exp,
                             input logic err, input logic [2:0] flg, input logic chkf);
        for (int i = 0; i < PW; i++) begin
            t_prog[n_entries][i] = (i < code.size()) ? code[i] : HALT_WORD;
        end
        t_name[n_entries]  = name;
        t_addr[n_entries]  = addr;
        t_exp[n_entries]   = exp;
        t_err[n_entries]   = err;
        t_flags[n_entries] = flg;
        t_chkf[n_entries]  = chkf;
        n_entries++;
    endtask

    task automatic add_branch(input string name, input logic [3:0] cond, input word_t addr);
        word_t exp;
        // xor R1,R1 leaves c=0, z=1, n=0 ahead of the branch.
        exp  = branch_taken(cond, 3'b010) ? 16'h0011 : 16'h0022;
        code = '{enc_imm(`TINY16_OP_LDI, 3, addr[7:0]), enc(`TINY16_OP_ALU, 1, 1, `TINY16_ALU_XOR),
                 enc_imm(`TINY16_OP_LDI, 4, 8'h11), enc_imm(`TINY16_OP_BR, cond, 8'h01),
                 enc_imm(`TINY16_OP_LDI, 4, 8'h22), enc(`TINY16_OP_ST, 4, 3, 0), HALT_WORD};
        add_entry(name, addr, exp, 1'b0, 3'b000, 1'b0);
    endtask

    task automatic build_table();
        logic [7:0]  a8;
        logic [7:0]  b8;
        logic [34:0] m;
        word_t       raddr;
        n_entries = 0;
        code = '{enc_imm(`TINY16_OP_LDI, 1, 8'h9c), enc_imm(`TINY16_OP_LDI, 2, 8'h40),
                 enc(`TINY16_OP_ST, 1, 2, 0), HALT_WORD};
        add_entry("ldi_st", 16'h0040, sext8(8'h9c), 1'b0, 3'b000, 1'b0);
        for (int op = 0; op < 8; op++) begin
            a8    = 8'($urandom);
            b8    = 8'($urandom);
            raddr = 16'h0020 + word_t'(2 * op);
            m     = alu_model(4'(op), sext8(a8), sext8(b8));
            code  = '{enc_imm(`TINY16_OP_LDI, 1, a8), enc_imm(`TINY16_OP_LDI, 2, b8),
                      enc_imm(`TINY16_OP_LDI, 3, raddr[7:0]), enc(`TINY16_OP_ALU, 1, 2, 4'(op)),
                      enc(`TINY16_OP_ST, 1, 3, 0), HALT_WORD};
            if (op == `TINY16_ALU_MUL) begin
                // High word lands in R2 and goes to the next address.
                code = '{enc_imm(`TINY16_OP_LDI, 1, a8), enc_imm(`TINY16_OP_LDI, 2, b8),
                         enc_imm(`TINY16_OP_LDI, 3, raddr[7:0]),
                         enc_imm(`TINY16_OP_LDI, 4, raddr[7:0] + 8'h01),
                         enc(`TINY16_OP_ALU, 1, 2, 4'(op)), enc(`TINY16_OP_ST, 1, 3, 0),
                         enc(`TINY16_OP_ST, 2, 4, 0), HALT_WORD};
                add_entry("mul_lo", raddr, m[15:0], 1'b0, m[34:32], 1'b1);
                add_entry("mul_hi", raddr + 16'h0001, m[31:16], 1'b0, m[34:32], 1'b1);
            end else begin
                add_entry(alu_names[op], raddr, m[15:0], 1'b0, m[34:32], 1'b1);
            end
        end
        add_branch("br_z_taken", 4'h2, 16'h0048);
        add_branch("br_not_z", 4'ha, 16'h0049);
        add_branch("br_not_n", 4'h9, 16'h004a);
        add_branch("br_c", 4'h4, 16'h004b);
        code = '{enc_imm(`TINY16_OP_LDW, 1, 8'h00), 16'hbeef, enc_imm(`TINY16_OP_LDI, 2, 8'h51),
                 enc(`TINY16_OP_ST, 1, 2, 0), enc(`TINY16_OP_LD, 4, 2, 0),
                 enc_imm(`TINY16_OP_LDI, 5, 8'h52), enc(`TINY16_OP_ST, 4, 5, 0), HALT_WORD};
        add_entry("ldw", 16'h0051, 16'hbeef, 1'b0, 3'b000, 1'b0);
        add_entry("ld", 16'h0052, 16'hbeef, 1'b0, 3'b000, 1'b0);
        code = '{enc_imm(`TINY16_OP_LDI, 15, 8'h60), enc_imm(`TINY16_OP_LDI, 3, 8'h77),
                 enc(`TINY16_OP_PUSH, 3, 0, 0), enc_imm(`TINY16_OP_LDI, 4, 8'h61),
                 enc(`TINY16_OP_ST, 15, 4, 0), HALT_WORD};
        add_entry("push_data", 16'h0060 - 16'h0001, 16'h0077, 1'b0, 3'b000, 1'b0);
        add_entry("push_sp", 16'h0061, 16'h0060 - 16'h0001, 1'b0, 3'b000, 1'b0);
        code = '{enc_imm(`TINY16_OP_LDI, 1, 8'h33), enc_imm(`TINY16_OP_LDI, 2, 8'h63), HALT_WORD,
                 enc(`TINY16_OP_ST, 1, 2, 0), HALT_WORD};
        add_entry("hlt_stops", 16'h0063, sentinel(n_entries), 1'b0, 3'b000, 1'b0);
        code = '{enc_imm(`TINY16_OP_LDI, 1, 8'h33), enc_imm(`TINY16_OP_LDI, 2, 8'h64), 16'h9000,
                 enc(`TINY16_OP_ST, 1, 2, 0), HALT_WORD};
        add_entry("bad_opcode", 16'h0064, sentinel(n_entries), 1'b1, 3'b000, 1'b0);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #10;
        reset    = 1'b0;
        run      = 1'b0;
        host_req = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b1;
    endtask

    // One four-phase transfer on the host port.
    task automatic host_access(input logic we, input word_t addr, input word_t wdata,
                               output word_t rdata);
        @(posedge clk);
        #10;
        host_cmd.we    = we;
        host_cmd.addr  = addr;
        host_cmd.wdata = wdata;
        host_req       = 1'b1;
        do begin
            @(posedge clk);
            #10;
        end while (!host_ack);
        rdata    = host_rdata;
        host_req = 1'b0;
        do begin
            @(posedge clk);
            #10;
        end while (host_ack);
    endtask

    task automatic run_entry(input int k);
        word_t rdata;
        apply_reset();
        checks++;
        assert (stage == S0) else begin
            errors++;
            $display("** Error %s: stage after reset expected %0d, actual %0d", t_name[k],
                     S0, stage);
        end
        for (int i = 0; i < PW; i++) begin
            host_access(1'b1, word_t'(i), t_prog[k][i], rdata);
        end
        host_access(1'b1, t_addr[k], sentinel(k), rdata);
        @(posedge clk);
        #10;
        run = 1'b1;
        do begin
            @(posedge clk);
            #10;
        end while (!hlt);
        run = 1'b0;
        host_access(1'b0, t_addr[k], 16'h0000, rdata);
        checks++;
        assert (rdata == t_exp[k]) else begin
            errors++;
            $display("** Error %s: result expected %h, actual %h", t_name[k], t_exp[k], rdata);
        end
        checks++;
        assert (error == t_err[k]) else begin
            errors++;
            $display("** Error %s: error flag expected %b, actual %b", t_name[k], t_err[k], error);
        end
        if (t_chkf[k]) begin
            checks++;
            assert (u_dut.u_core.flags == t_flags[k]) else begin
                errors++;
                $display("** Error %s: flags czn expected %b, actual %b", t_name[k],
                         t_flags[k], u_dut.u_core.flags);
            end
        end
    endtask

    initial begin
        reset    = 1'b0;
        run      = 1'b0;
        host_req = 1'b0;
        host_cmd = '0;
        errors   = 0;
        checks   = 0;
        void'($urandom(32'h2e346f47));
        build_table();
        assert (n_entries == NT) else begin
            errors++;
            $display("The test table holds %0d entries instead of %0d", n_entries, NT);
        end
        for (int k = 0; k < n_entries; k++) begin
            run_entry(k);
        end
        assert_fails = u_dut.u_assert.fail_count;
        $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("The run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* tiny16_system.f */
+incdir+include
logic/tiny16_pkg.sv
logic/tiny16_alu.sv
logic/tiny16_regfile.sv
logic/tiny16_microcode.sv
logic/tiny16_core.sv
logic/tiny16_memory.sv
logic/tiny16_system.sv
tb/tiny16_assert.sv
tb/tiny16_tb.sv

/* Bender.yml */
package:
  name: tiny16

export_include_dirs:
  - include

sources:
  - logic/tiny16_pkg.sv
  - logic/tiny16_alu.sv
  - logic/tiny16_regfile.sv
  - logic/tiny16_microcode.sv
  - logic/tiny16_core.sv
  - logic/tiny16_memory.sv
  - logic/tiny16_system.sv
  - target: simulation
    files:
      - tb/tiny16_assert.sv
      - tb/tiny16_tb.sv
